// File: design/mem_geom_pkg.sv
`default_nettype none

package mem_geom_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // ----------------------------------------------------------------------
  // Memory geometry
  // ----------------------------------------------------------------------
  // Byte offset bits inside one data word
  localparam int LSB       = $clog2(STRB_W);
  localparam int MEM_AW    = ADDR_W - LSB;
  localparam int MEM_DEPTH = 1 << MEM_AW;

endpackage

`default_nettype wire

// File: design/axi_chan_pkg.sv
`default_nettype none

package axi_chan_pkg;

  import mem_geom_pkg::*;

  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
  localparam logic [RESP_W-1:0]  RESP_OKAY   = 2'b00;

  // ----------------------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } axi_aw_t;

  // Read requests carry the same fields
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
  } axi_r_t;

  // Address of the following beat; WRAP falls through to INCR
  function automatic logic [ADDR_W-1:0] next_beat_addr(
    input logic [ADDR_W-1:0]  addr,
    input logic [SIZE_W-1:0]  size,
    input logic [BURST_W-1:0] burst
  );
    logic [ADDR_W-1:0] step;
    step = ADDR_W'(1) << size;
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return addr + step;
  endfunction

endpackage

`default_nettype wire

// File: design/axi_skid_buffer.sv
`default_nettype none

module axi_skid_buffer #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      rst_n,

  input  wire      i_valid,
  input  payload_t i_data,
  output logic     o_ready,

  output logic     o_valid,
  output payload_t o_data,
  input  wire      i_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     out_free;
  logic     in_fire;

  // Upstream ready comes straight from the spare slot flop
  assign o_ready  = !skid_valid;
  assign out_free = !o_valid || i_ready;
  assign in_fire  = i_valid && o_ready;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Spare entry drains first to keep order
      o_valid    <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (out_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (!out_free && in_fire) begin
      skid_data <= i_data;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> $stable(o_data))
    else $error("skid buffer payload changed while stalled");

endmodule

`default_nettype wire

// File: design/axi_mem_array.sv
`default_nettype none

module axi_mem_array
  import mem_geom_pkg::*;
(
  input  wire                clk,

  input  wire                i_wr_en,
  input  wire  [MEM_AW-1:0]  i_wr_addr,
  input  wire  [DATA_W-1:0]  i_wr_data,
  input  wire  [STRB_W-1:0]  i_wr_strb,

  input  wire                i_rd_en,
  input  wire  [MEM_AW-1:0]  i_rd_addr,
  output logic [DATA_W-1:0]  o_rd_data
);

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  // ----------------------------------------------------------------------
  // Write port with one enable per byte lane
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_W; i++) begin
      if (i_wr_en && i_wr_strb[i]) begin
        mem[i_wr_addr][8*i +: 8] <= i_wr_data[8*i +: 8];
      end
    end
  end

  // Registered read that holds its output between reads
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/axi_write_engine.sv
`default_nettype none

module axi_write_engine
  import mem_geom_pkg::*, axi_chan_pkg::*;
(
  input  wire                clk,
  input  wire                rst_n,

  input  wire                i_aw_valid,
  input  axi_aw_t            i_aw,
  output logic               o_aw_ready,

  input  wire                i_w_valid,
  input  axi_w_t             i_w,
  output logic               o_w_ready,

  output logic               o_b_valid,
  output axi_b_t             o_b,
  input  wire                i_b_ready,

  output logic               o_wr_en,
  output logic [MEM_AW-1:0]  o_wr_addr,
  output logic [DATA_W-1:0]  o_wr_data,
  output logic [STRB_W-1:0]  o_wr_strb
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_BURST,
    WR_RESP
  } wr_state_t;

  wr_state_t state;
  wr_state_t state_d;

  // Burst context latched from AW
  logic [ID_W-1:0]    w_id;
  logic [ADDR_W-1:0]  w_addr;
  logic [SIZE_W-1:0]  w_size;
  logic [BURST_W-1:0] w_burst;

  logic [ID_W-1:0]    cur_id;
  logic [ADDR_W-1:0]  cur_addr;
  logic [SIZE_W-1:0]  cur_size;
  logic [BURST_W-1:0] cur_burst;

  logic               b_valid;
  logic [ID_W-1:0]    b_id;
  logic               b_free;
  logic               b_load;
  logic               aw_fire;
  logic               w_fire;

  assign o_aw_ready = (state == WR_IDLE);
  // First beat may ride along with its AW
  assign o_w_ready  = (state == WR_IDLE) ? i_aw_valid : (state == WR_BURST);

  assign aw_fire = i_aw_valid && o_aw_ready;
  assign w_fire  = i_w_valid && o_w_ready;
  assign b_free  = !b_valid || i_b_ready;

  // In IDLE the context comes straight from the AW buffer
  always_comb begin
    if (state == WR_IDLE) begin
      cur_id    = i_aw.id;
      cur_addr  = i_aw.addr;
      cur_size  = i_aw.size;
      cur_burst = i_aw.burst;
    end else begin
      cur_id    = w_id;
      cur_addr  = w_addr;
      cur_size  = w_size;
      cur_burst = w_burst;
    end
  end

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state;
    b_load  = 1'b0;
    case (state)
      WR_IDLE: begin
        if (aw_fire) begin
          state_d = WR_BURST;
        end
      end
      WR_BURST: begin
      end
      WR_RESP: begin
        if (b_free) begin
          state_d = WR_IDLE;
          b_load  = 1'b1;
        end
      end
      default: state_d = WR_IDLE;
    endcase

    // Burst ends on WLAST and AWLEN is not tracked
    if (w_fire && i_w.last) begin
      if (b_free) begin
        state_d = WR_IDLE;
        b_load  = 1'b1;
      end else begin
        state_d = WR_RESP;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= WR_IDLE;
      b_valid <= 1'b0;
    end else begin
      state   <= state_d;
      b_valid <= b_load || (b_valid && !i_b_ready);
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      w_id    <= i_aw.id;
      w_size  <= i_aw.size;
      w_burst <= i_aw.burst;
    end
    if (w_fire) begin
      w_addr <= next_beat_addr(cur_addr, cur_size, cur_burst);
    end else if (aw_fire) begin
      w_addr <= i_aw.addr;
    end
    if (b_load) begin
      b_id <= cur_id;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign o_wr_en   = w_fire;
  assign o_wr_addr = cur_addr[ADDR_W-1:LSB];
  assign o_wr_data = i_w.data;
  assign o_wr_strb = i_w.strb;

  assign o_b_valid = b_valid;
  assign o_b       = '{id: b_id, resp: RESP_OKAY};

  // A burst parked in RESP sits behind a pending B and takes no beats
  a_no_w_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
    state == WR_RESP |-> b_valid && !w_fire)
    else $error("W beat accepted while a response was pending");

endmodule

`default_nettype wire

// File: design/axi_read_engine.sv
`default_nettype none

module axi_read_engine
  import mem_geom_pkg::*, axi_chan_pkg::*;
(
  input  wire                clk,
  input  wire                rst_n,

  input  wire                i_ar_valid,
  input  axi_ar_t            i_ar,
  output logic               o_ar_ready,

  output logic               o_r_valid,
  output axi_r_t             o_r,
  input  wire                i_r_ready,

  output logic               o_rd_en,
  output logic [MEM_AW-1:0]  o_rd_addr,
  input  wire  [DATA_W-1:0]  i_rd_data
);

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_t;

  rd_state_t state;
  rd_state_t state_d;
  logic      ar_ready_d;

  logic [ID_W-1:0]    r_id;
  logic [ADDR_W-1:0]  r_addr;
  logic [LEN_W-1:0]   r_len;
  logic [SIZE_W-1:0]  r_size;
  logic [BURST_W-1:0] r_burst;

  logic [ID_W-1:0]    cur_id;
  logic [ADDR_W-1:0]  cur_addr;
  logic [LEN_W-1:0]   cur_len;
  logic [SIZE_W-1:0]  cur_size;
  logic [BURST_W-1:0] cur_burst;

  // Beat currently presented on R
  logic               r_valid;
  logic               r_last;
  logic [ID_W-1:0]    r_out_id;

  logic               ar_fire;
  logic               r_free;
  logic               issue;

  assign ar_fire = i_ar_valid && o_ar_ready;
  assign r_free  = !r_valid || i_r_ready;
  // One array read per free R slot
  assign issue   = r_free && (ar_fire || state == RD_BURST);

  always_comb begin
    if (state == RD_IDLE) begin
      cur_id    = i_ar.id;
      cur_addr  = i_ar.addr;
      cur_len   = i_ar.len;
      cur_size  = i_ar.size;
      cur_burst = i_ar.burst;
    end else begin
      cur_id    = r_id;
      cur_addr  = r_addr;
      cur_len   = r_len;
      cur_size  = r_size;
      cur_burst = r_burst;
    end
  end

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d    = state;
    ar_ready_d = o_ar_ready;
    if (ar_fire) begin
      state_d    = RD_BURST;
      ar_ready_d = 1'b0;
    end
    // Last beat issued so AR opens again
    if (issue && cur_len == '0) begin
      state_d    = RD_IDLE;
      ar_ready_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= RD_IDLE;
      o_ar_ready <= 1'b1;
      r_valid    <= 1'b0;
      r_last     <= 1'b0;
    end else begin
      state      <= state_d;
      o_ar_ready <= ar_ready_d;
      r_valid    <= issue || (r_valid && !i_r_ready);
      if (issue) begin
        r_last <= (cur_len == '0);
      end else if (i_r_ready) begin
        r_last <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r_id    <= i_ar.id;
      r_size  <= i_ar.size;
      r_burst <= i_ar.burst;
    end
    if (issue) begin
      r_addr   <= next_beat_addr(cur_addr, cur_size, cur_burst);
      r_len    <= cur_len - 1'b1;
      r_out_id <= cur_id;
    end else if (ar_fire) begin
      r_addr <= i_ar.addr;
      r_len  <= i_ar.len;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign o_rd_en   = issue;
  assign o_rd_addr = cur_addr[ADDR_W-1:LSB];

  // Array data is held while R stalls since no read is issued
  assign o_r_valid = r_valid;
  assign o_r       = '{id: r_out_id, data: i_rd_data, resp: RESP_OKAY, last: r_last};

  a_last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    o_r.last |-> o_r_valid)
    else $error("rlast high without rvalid");

endmodule

`default_nettype wire

// File: design/axi_mem_top.sv
`default_nettype none

module axi_mem_top
  import mem_geom_pkg::*, axi_chan_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,

  input  wire     i_aw_valid,
  input  axi_aw_t i_aw,
  output logic    o_aw_ready,

  input  wire     i_w_valid,
  input  axi_w_t  i_w,
  output logic    o_w_ready,

  output logic    o_b_valid,
  output axi_b_t  o_b,
  input  wire     i_b_ready,

  input  wire     i_ar_valid,
  input  axi_ar_t i_ar,
  output logic    o_ar_ready,

  output logic    o_r_valid,
  output axi_r_t  o_r,
  input  wire     i_r_ready
);

  axi_aw_t           aw_sb;
  logic              aw_sb_valid;
  logic              aw_sb_ready;

  axi_w_t            w_sb;
  logic              w_sb_valid;
  logic              w_sb_ready;

  logic              wr_en;
  logic [MEM_AW-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;

  logic              rd_en;
  logic [MEM_AW-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  // ----------------------------------------------------------------------
  // Write path
  // ----------------------------------------------------------------------
  axi_skid_buffer #(
    .payload_t (axi_aw_t)
  ) u_aw_skid (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_aw_valid),
    .i_data  (i_aw),
    .o_ready (o_aw_ready),
    .o_valid (aw_sb_valid),
    .o_data  (aw_sb),
    .i_ready (aw_sb_ready)
  );

  axi_skid_buffer #(
    .payload_t (axi_w_t)
  ) u_w_skid (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_w_valid),
    .i_data  (i_w),
    .o_ready (o_w_ready),
    .o_valid (w_sb_valid),
    .o_data  (w_sb),
    .i_ready (w_sb_ready)
  );

  axi_write_engine u_write_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (aw_sb_valid),
    .i_aw       (aw_sb),
    .o_aw_ready (aw_sb_ready),
    .i_w_valid  (w_sb_valid),
    .i_w        (w_sb),
    .o_w_ready  (w_sb_ready),
    .o_b_valid  (o_b_valid),
    .o_b        (o_b),
    .i_b_ready  (i_b_ready),
    .o_wr_en    (wr_en),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .o_wr_strb  (wr_strb)
  );

  // ----------------------------------------------------------------------
  // Read path with AR going straight to the engine
  // ----------------------------------------------------------------------
  axi_read_engine u_read_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ar_valid (i_ar_valid),
    .i_ar       (i_ar),
    .o_ar_ready (o_ar_ready),
    .o_r_valid  (o_r_valid),
    .o_r        (o_r),
    .i_r_ready  (i_r_ready),
    .o_rd_en    (rd_en),
    .o_rd_addr  (rd_addr),
    .i_rd_data  (rd_data)
  );

  axi_mem_array u_mem_array (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: bench/axi_mem_tb.sv
`default_nettype none

module axi_mem_tb
  import mem_geom_pkg::*, axi_chan_pkg::*;
();

  localparam int              TIMEOUT    = 500;
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;

  logic    clk;
  logic    rst_n;

  logic    i_aw_valid;
  axi_aw_t i_aw;
  logic    o_aw_ready;
  logic    i_w_valid;
  axi_w_t  i_w;
  logic    o_w_ready;
  logic    o_b_valid;
  axi_b_t  o_b;
  logic    i_b_ready = 1'b0;
  logic    i_ar_valid;
  axi_ar_t i_ar;
  logic    o_ar_ready;
  logic    o_r_valid;
  axi_r_t  o_r;
  logic    i_r_ready = 1'b0;

  // Reference byte model and per-burst beat buffers
  logic [7:0]        ref_mem [256];
  logic [DATA_W-1:0] beat_data [16];
  logic [STRB_W-1:0] beat_strb [16];

  // Expected R beats in a ring that fills when an AR is issued
  axi_r_t            exp_mem [64];
  axi_r_t            exp_r;
  int unsigned       exp_wr;
  int unsigned       exp_rd;
  int unsigned       b_issued;
  int unsigned       b_count;
  logic [ID_W-1:0]   exp_bid;

  string             test_name = "reset";
  logic              stall_en = 1'b0;
  logic [31:0]       data_seed = 32'd36;
  logic [31:0]       stall_seed = 32'd36;

  logic              r_fire;
  logic              b_fire;

  axi_mem_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (i_aw_valid),
    .i_aw       (i_aw),
    .o_aw_ready (o_aw_ready),
    .i_w_valid  (i_w_valid),
    .i_w        (i_w),
    .o_w_ready  (o_w_ready),
    .o_b_valid  (o_b_valid),
    .o_b        (o_b),
    .i_b_ready  (i_b_ready),
    .i_ar_valid (i_ar_valid),
    .i_ar       (i_ar),
    .o_ar_ready (o_ar_ready),
    .o_r_valid  (o_r_valid),
    .o_r        (o_r),
    .i_r_ready  (i_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    data_seed = xorshift32(data_seed);
    return data_seed;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation aborted");
  endtask

  task automatic stop_with_error(input string why);
    $display("Error in %s: %s", test_name, why);
    abort_run();
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch in %s (%s): expected %h actual %h", test_name, field,
             expected, actual);
    abort_run();
  endtask

  task automatic tick_or_timeout(inout int waited, input string what);
    @(posedge clk);
    #1;
    waited++;
    if (waited > TIMEOUT) begin
      stop_with_error({"timeout waiting for ", what});
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus drivers
  // ----------------------------------------------------------------------
  task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input int beats, input logic [BURST_W-1:0] burst);
    int          waited;
    logic [7:0]  a;
    exp_bid  = id;
    b_issued = b_issued + 1;
    i_aw = '{id: id, addr: addr, len: 8'(beats - 1), size: 3'd1, burst: burst};
    i_aw_valid = 1'b1;
    waited = 0;
    while (!o_aw_ready) tick_or_timeout(waited, "awready");
    @(posedge clk);
    #1;
    i_aw_valid = 1'b0;
    for (int k = 0; k < beats; k++) begin
      i_w = '{data: beat_data[k], strb: beat_strb[k], last: (k == beats - 1)};
      i_w_valid = 1'b1;
      waited = 0;
      while (!o_w_ready) tick_or_timeout(waited, "wready");
      @(posedge clk);
      #1;
    end
    i_w_valid = 1'b0;
    waited = 0;
    while (b_count != b_issued) tick_or_timeout(waited, "write response");
    // Commit the burst to the model once B is accepted
    a = addr;
    for (int k = 0; k < beats; k++) begin
      if (beat_strb[k][0]) begin
        ref_mem[{a[7:1], 1'b0}] = beat_data[k][7:0];
      end
      if (beat_strb[k][1]) begin
        ref_mem[{a[7:1], 1'b1}] = beat_data[k][15:8];
      end
      if (burst != BURST_FIXED) begin
        a = a + 8'd2;
      end
    end
  endtask

  task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input int beats, input logic [BURST_W-1:0] burst);
    int          waited;
    logic [7:0]  a;
    a = addr;
    for (int k = 0; k < beats; k++) begin
      exp_mem[exp_wr[5:0]] = '{id: id,
                               data: {ref_mem[{a[7:1], 1'b1}], ref_mem[{a[7:1], 1'b0}]},
                               resp: RESP_OKAY,
                               last: (k == beats - 1)};
      exp_wr = exp_wr + 1;
      if (burst != BURST_FIXED) begin
        a = a + 8'd2;
      end
    end
    i_ar = '{id: id, addr: addr, len: 8'(beats - 1), size: 3'd1, burst: burst};
    i_ar_valid = 1'b1;
    waited = 0;
    while (!o_ar_ready) tick_or_timeout(waited, "arready");
    @(posedge clk);
    #1;
    i_ar_valid = 1'b0;
    waited = 0;
    while (exp_rd != exp_wr) tick_or_timeout(waited, "read data beats");
  endtask

  // Ready stalls for B and R
  always @(posedge clk) begin
    #1;
    if (stall_en) begin
      stall_seed = xorshift32(stall_seed);
      i_b_ready  = stall_seed[3];
      i_r_ready  = stall_seed[11];
    end else begin
      i_b_ready = 1'b1;
      i_r_ready = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Monitor and checks
  // ----------------------------------------------------------------------
  assign r_fire = o_r_valid && i_r_ready;
  assign b_fire = o_b_valid && i_b_ready;
  assign exp_r  = exp_mem[exp_rd[5:0]];

  always @(posedge clk) begin
    if (!rst_n) begin
      b_count <= 0;
      exp_rd  <= 0;
    end else begin
      if (b_fire) begin
        b_count <= b_count + 1;
      end
      if (r_fire) begin
        exp_rd <= exp_rd + 1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> !o_b_valid && !o_r_valid && o_ar_ready)
    else stop_with_error("bus outputs not idle after reset");

  a_r_expected: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> exp_rd != exp_wr)
    else stop_with_error("R beat arrived with no read outstanding");

  a_r_data: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> o_r.data == exp_r.data)
    else report_mismatch("rdata", $sampled(exp_r.data), $sampled(o_r.data));

  a_r_id: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> o_r.id == exp_r.id)
    else report_mismatch("rid", $sampled(exp_r.id), $sampled(o_r.id));

  a_r_last: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> o_r.last == exp_r.last)
    else report_mismatch("rlast", $sampled(exp_r.last), $sampled(o_r.last));

  a_r_resp: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> o_r.resp == RESP_OKAY)
    else report_mismatch("rresp", RESP_OKAY, $sampled(o_r.resp));

  a_b_expected: assert property (@(posedge clk) disable iff (!rst_n)
    b_fire |-> b_count != b_issued)
    else stop_with_error("B response arrived with no write outstanding");

  a_b_id: assert property (@(posedge clk) disable iff (!rst_n)
    b_fire |-> o_b.id == exp_bid)
    else report_mismatch("bid", $sampled(exp_bid), $sampled(o_b.id));

  a_b_resp: assert property (@(posedge clk) disable iff (!rst_n)
    b_fire |-> o_b.resp == RESP_OKAY)
    else report_mismatch("bresp", RESP_OKAY, $sampled(o_b.resp));

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0]        r;
    logic [31:0]        rnd;
    int                 beats;
    logic [BURST_W-1:0] burst;
    logic [7:0]         addr;
    logic [7:0]         fill_addr;
    rst_n      = 1'b0;
    i_aw_valid = 1'b0;
    i_aw       = '0;
    i_w_valid  = 1'b0;
    i_w        = '0;
    i_ar_valid = 1'b0;
    i_ar       = '0;
    exp_wr     = 0;
    b_issued   = 0;
    exp_bid    = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Whole array gets a pattern of its byte addresses
    test_name = "fill";
    for (int blk = 0; blk < 8; blk++) begin
      for (int k = 0; k < 16; k++) begin
        fill_addr    = 8'(blk * 32 + k * 2);
        beat_data[k] = {fill_addr ^ 8'hA4, fill_addr ^ 8'hA5};
        beat_strb[k] = 2'b11;
      end
      write_burst(4'h0, 8'(blk * 32), 16, BURST_INCR);
    end

    test_name = "single";
    rnd          = next_random();
    beat_data[0] = rnd[15:0];
    beat_strb[0] = 2'b11;
    write_burst(4'h1, 8'h10, 1, BURST_INCR);
    read_burst(4'h2, 8'h10, 1, BURST_INCR);

    test_name = "incr_burst";
    for (int k = 0; k < 4; k++) begin
      rnd          = next_random();
      beat_data[k] = rnd[15:0];
      beat_strb[k] = 2'b11;
    end
    write_burst(4'h3, 8'h20, 4, BURST_INCR);
    read_burst(4'h4, 8'h20, 4, BURST_INCR);

    test_name = "strobe";
    beat_data[0] = 16'hA1B2;
    beat_strb[0] = 2'b11;
    write_burst(4'h5, 8'h30, 1, BURST_INCR);
    beat_data[0] = 16'h55CC;
    beat_strb[0] = 2'b01;
    write_burst(4'h6, 8'h30, 1, BURST_INCR);
    beat_data[0] = 16'h7E00;
    beat_strb[0] = 2'b10;
    write_burst(4'h7, 8'h32, 1, BURST_INCR);
    read_burst(4'h8, 8'h30, 2, BURST_INCR);

    test_name = "fixed_burst";
    for (int k = 0; k < 4; k++) begin
      rnd          = next_random();
      beat_data[k] = rnd[15:0];
      beat_strb[k] = 2'b11;
    end
    write_burst(4'h9, 8'h40, 4, BURST_FIXED);
    read_burst(4'hA, 8'h40, 4, BURST_FIXED);
    read_burst(4'hB, 8'h40, 2, BURST_INCR);

    // Random bursts under B and R back pressure
    test_name = "random_stall";
    stall_en  = 1'b1;
    for (int n = 0; n < 24; n++) begin
      r     = next_random();
      beats = 1 + int'(r[1:0]);
      burst = r[2] ? BURST_INCR : BURST_FIXED;
      addr  = {r[15:9], 1'b0};
      for (int k = 0; k < beats; k++) begin
        rnd          = next_random();
        beat_data[k] = rnd[15:0];
        beat_strb[k] = rnd[17:16];
      end
      write_burst(r[7:4], addr, beats, burst);
      read_burst(r[11:8], addr, beats, r[3] ? BURST_INCR : BURST_FIXED);
    end
    stall_en = 1'b0;

    test_name = "end_of_run";
    if (exp_rd != exp_wr || b_count != b_issued) begin
      stop_with_error("responses still outstanding");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: compile.f
design/mem_geom_pkg.sv
design/axi_chan_pkg.sv
design/axi_skid_buffer.sv
design/axi_mem_array.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/axi_mem_top.sv
bench/axi_mem_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module axi_mem_tb \
		-f compile.f -Mdir obj_dir -o axi_mem_sim

run: compile
	-./obj_dir/axi_mem_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
